/* hdl/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and register file
`define CPU_XLEN 32
`define CPU_RIDX 5
`define CPU_NREGS 32

// program counter counts instruction words
`define CPU_PC_W 14

// one fetch word carries an instruction pair
`define CPU_FETCH_W 64

// wait window entries
`define CPU_WIN_DEPTH 3

// output port byte
`define CPU_IO_W 8

`endif

/* hdl/cpu_pkg.sv */
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_ADDI = 6'h06,
		OP_LUI  = 6'h07,
		OP_OUT  = 6'h08,
		OP_J    = 6'h09
	} opcode_e;

	// unit that executes the entry, none for J and NOP
	typedef enum logic [1:0] {
		UNIT_NONE = 2'd0,
		UNIT_ALU  = 2'd1,
		UNIT_OUT  = 2'd2
	} unit_e;

	typedef struct packed {
		logic [`CPU_PC_W-1:0] pc;
		opcode_e              opcode;
		logic [`CPU_RIDX-1:0] rd;
		logic [`CPU_RIDX-1:0] rs;
		logic [`CPU_RIDX-1:0] rt;
		logic [15:0]          imm;
		unit_e                unit;
		logic                 rs_used;
		logic                 rt_used;
		logic                 rd_used;
	} decoded_t;

endpackage

`default_nettype wire

/* hdl/fetch_decode.sv */
`default_nettype none

`include "cpu_macros.svh"

module fetch_decode (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire [`CPU_FETCH_W-1:0]  i_i_rdata,
	input  wire                     i_stall,
	output logic [`CPU_PC_W-2:0]    o_i_addr,
	output cpu_pkg::decoded_t       o_slot0,
	output logic                    o_slot0_vld,
	output cpu_pkg::decoded_t       o_slot1,
	output logic                    o_slot1_vld
);

	logic [`CPU_PC_W-1:0] pc, f_pc, skid_pc, cur_pc, target;
	logic [`CPU_FETCH_W-1:0] skid_data, cur_data;
	logic f_vld, skid_vld, cur_vld;
	logic j0, j1, redirect;

	function automatic cpu_pkg::decoded_t decode(input logic [`CPU_XLEN-1:0] ins,
			input logic [`CPU_PC_W-1:0] ipc);
		cpu_pkg::decoded_t d;
		d = '0;
		d.pc = ipc;
		d.opcode = cpu_pkg::opcode_e'(ins[31:26]);
		d.rd = ins[25:21];
		d.rs = ins[20:16];
		d.rt = ins[15:11];
		d.imm = ins[15:0];
		d.unit = cpu_pkg::UNIT_NONE;
		case (ins[31:26])
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
			cpu_pkg::OP_XOR: begin
				d.unit = cpu_pkg::UNIT_ALU;
				d.rs_used = 1'b1;
				d.rt_used = 1'b1;
				d.rd_used = (ins[25:21] != '0);
			end
			cpu_pkg::OP_ADDI: begin
				d.unit = cpu_pkg::UNIT_ALU;
				d.rs_used = 1'b1;
				d.rd_used = (ins[25:21] != '0);
			end
			cpu_pkg::OP_LUI: begin
				d.unit = cpu_pkg::UNIT_ALU;
				d.rd_used = (ins[25:21] != '0);
			end
			cpu_pkg::OP_OUT: begin
				d.unit = cpu_pkg::UNIT_OUT;
				d.rs_used = 1'b1;
			end
			default: begin
				d.unit = cpu_pkg::UNIT_NONE;
			end
		endcase
		return d;
	endfunction

	assign o_i_addr = pc[`CPU_PC_W-1:1];

	// the skid pair takes priority over the memory output
	assign cur_data = skid_vld ? skid_data : i_i_rdata;
	assign cur_pc = skid_vld ? skid_pc : f_pc;
	assign cur_vld = skid_vld | f_vld;

	assign o_slot0 = decode(cur_data[`CPU_FETCH_W-1:`CPU_XLEN], {cur_pc[`CPU_PC_W-1:1], 1'b0});
	assign o_slot1 = decode(cur_data[`CPU_XLEN-1:0], {cur_pc[`CPU_PC_W-1:1], 1'b1});

	// odd jump target enters in the second half
	assign o_slot0_vld = cur_vld && !cur_pc[0];
	assign j0 = o_slot0_vld && o_slot0.opcode == cpu_pkg::OP_J;
	assign o_slot1_vld = cur_vld && !j0;
	assign j1 = o_slot1_vld && o_slot1.opcode == cpu_pkg::OP_J;

	assign redirect = !i_stall && (j0 || j1);
	assign target = j0 ? o_slot0.imm[`CPU_PC_W-1:0] : o_slot1.imm[`CPU_PC_W-1:0];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc <= '0;
			f_vld <= 1'b0;
			skid_vld <= 1'b0;
		end else begin
			if (redirect) begin
				// the pair requested now is on the wrong path
				pc <= target;
				f_vld <= 1'b0;
			end else begin
				f_vld <= 1'b1;
				if (!i_stall) begin
					pc <= {pc[`CPU_PC_W-1:1] + 1'b1, 1'b0};
				end
			end
			if (i_stall && !skid_vld) begin
				skid_vld <= f_vld;
			end else if (!i_stall) begin
				skid_vld <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		// held pc is requested again while stalled
		f_pc <= pc;
		if (i_stall && !skid_vld) begin
			skid_data <= i_i_rdata;
			skid_pc <= f_pc;
		end
	end

endmodule

`default_nettype wire

/* hdl/issue_window.sv */
`default_nettype none

`include "cpu_macros.svh"

module issue_window (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire cpu_pkg::decoded_t  i_slot0,
	input  wire                     i_slot0_vld,
	input  wire cpu_pkg::decoded_t  i_slot1,
	input  wire                     i_slot1_vld,
	input  wire                     i_out_busy,
	input  wire                     i_wb0_vld,
	input  wire [`CPU_RIDX-1:0]     i_wb0_rd,
	input  wire                     i_wb1_vld,
	input  wire [`CPU_RIDX-1:0]     i_wb1_rd,
	input  wire [`CPU_XLEN-1:0]     i_rs0_val, i_rt0_val, i_rs1_val,
	input  wire [`CPU_XLEN-1:0]     i_rt1_val, i_rs2_val, i_rt2_val,
	output logic                    o_stall,
	output logic [`CPU_RIDX-1:0]    o_rs0_idx, o_rt0_idx, o_rs1_idx,
	output logic [`CPU_RIDX-1:0]    o_rt1_idx, o_rs2_idx, o_rt2_idx,
	output logic                    o_alu0_go,
	output cpu_pkg::opcode_e        o_alu0_op,
	output logic [`CPU_XLEN-1:0]    o_alu0_a, o_alu0_b,
	output logic [15:0]             o_alu0_imm,
	output logic [`CPU_RIDX-1:0]    o_alu0_rd,
	output logic                    o_alu1_go,
	output cpu_pkg::opcode_e        o_alu1_op,
	output logic [`CPU_XLEN-1:0]    o_alu1_a, o_alu1_b,
	output logic [15:0]             o_alu1_imm,
	output logic [`CPU_RIDX-1:0]    o_alu1_rd,
	output logic                    o_out_go,
	output logic [`CPU_XLEN-1:0]    o_out_data
);

	localparam int D = `CPU_WIN_DEPTH;

	cpu_pkg::decoded_t ent [D];
	cpu_pkg::decoded_t nxt [D];
	logic [D-1:0] ent_vld, nxt_vld, rdy, issued;
	logic [`CPU_NREGS-1:0] pending, pend_nxt;
	logic [`CPU_XLEN-1:0] rs_val [D];
	logic [`CPU_XLEN-1:0] rt_val [D];
	logic [1:0] alu0_idx, alu1_idx, out_idx, cnt;
	logic out_seen;

	function automatic logic reads_reg(cpu_pkg::decoded_t e, logic [`CPU_RIDX-1:0] r);
		return (e.rs_used && e.rs == r) || (e.rt_used && e.rt == r);
	endfunction

	assign o_rs0_idx = ent[0].rs;
	assign o_rt0_idx = ent[0].rt;
	assign o_rs1_idx = ent[1].rs;
	assign o_rt1_idx = ent[1].rt;
	assign o_rs2_idx = ent[2].rs;
	assign o_rt2_idx = ent[2].rt;
	assign rs_val[0] = i_rs0_val;
	assign rt_val[0] = i_rt0_val;
	assign rs_val[1] = i_rs1_val;
	assign rt_val[1] = i_rt1_val;
	assign rs_val[2] = i_rs2_val;
	assign rt_val[2] = i_rt2_val;

	always_comb begin
		for (int i = 0; i < D; i++) begin
			rdy[i] = ent_vld[i];
			if ((ent[i].rs_used && pending[ent[i].rs]) || (ent[i].rt_used && pending[ent[i].rt]) ||
					(ent[i].rd_used && pending[ent[i].rd]))
				rdy[i] = 1'b0;
			for (int j = 0; j < i; j++) begin
				// raw and waw on older writers
				if (ent_vld[j] && ent[j].rd_used && (reads_reg(ent[i], ent[j].rd) ||
						(ent[i].rd_used && ent[i].rd == ent[j].rd)))
					rdy[i] = 1'b0;
				// war on older readers
				if (ent_vld[j] && ent[i].rd_used && reads_reg(ent[j], ent[i].rd))
					rdy[i] = 1'b0;
			end
		end
	end

	always_comb begin
		o_alu0_go = 1'b0;
		o_alu1_go = 1'b0;
		o_out_go = 1'b0;
		alu0_idx = '0;
		alu1_idx = '0;
		out_idx = '0;
		out_seen = 1'b0;
		for (int i = 0; i < D; i++) begin
			if (rdy[i] && ent[i].unit == cpu_pkg::UNIT_ALU) begin
				if (!o_alu0_go) begin
					o_alu0_go = 1'b1;
					alu0_idx = 2'(i);
				end else if (!o_alu1_go) begin
					o_alu1_go = 1'b1;
					alu1_idx = 2'(i);
				end
			end
			// bytes leave in program order
			if (ent_vld[i] && ent[i].unit == cpu_pkg::UNIT_OUT) begin
				if (!out_seen && rdy[i] && !i_out_busy) begin
					o_out_go = 1'b1;
					out_idx = 2'(i);
				end
				out_seen = 1'b1;
			end
		end
		for (int i = 0; i < D; i++) begin
			issued[i] = (o_alu0_go && alu0_idx == 2'(i)) || (o_alu1_go && alu1_idx == 2'(i)) ||
					(o_out_go && out_idx == 2'(i));
		end
	end

	assign o_alu0_op = ent[alu0_idx].opcode;
	assign o_alu0_a = rs_val[alu0_idx];
	assign o_alu0_b = rt_val[alu0_idx];
	assign o_alu0_imm = ent[alu0_idx].imm;
	assign o_alu0_rd = ent[alu0_idx].rd;
	assign o_alu1_op = ent[alu1_idx].opcode;
	assign o_alu1_a = rs_val[alu1_idx];
	assign o_alu1_b = rt_val[alu1_idx];
	assign o_alu1_imm = ent[alu1_idx].imm;
	assign o_alu1_rd = ent[alu1_idx].rd;
	assign o_out_data = rs_val[out_idx];

	always_comb begin
		nxt = ent;
		nxt_vld = '0;
		cnt = '0;
		// survivors move toward entry 0
		for (int i = 0; i < D; i++) begin
			if (ent_vld[i] && !issued[i]) begin
				nxt[cnt] = ent[i];
				nxt_vld[cnt] = 1'b1;
				cnt = cnt + 1'b1;
			end
		end
		o_stall = (cnt >= 2'd2);
		if (!o_stall && i_slot0_vld && i_slot0.unit != cpu_pkg::UNIT_NONE) begin
			nxt[cnt] = i_slot0;
			nxt_vld[cnt] = 1'b1;
			cnt = cnt + 1'b1;
		end
		if (!o_stall && i_slot1_vld && i_slot1.unit != cpu_pkg::UNIT_NONE) begin
			nxt[cnt] = i_slot1;
			nxt_vld[cnt] = 1'b1;
		end
		pend_nxt = pending;
		if (i_wb0_vld)
			pend_nxt[i_wb0_rd] = 1'b0;
		if (i_wb1_vld)
			pend_nxt[i_wb1_rd] = 1'b0;
		if (o_alu0_go && ent[alu0_idx].rd_used)
			pend_nxt[o_alu0_rd] = 1'b1;
		if (o_alu1_go && ent[alu1_idx].rd_used)
			pend_nxt[o_alu1_rd] = 1'b1;
		pend_nxt[0] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ent_vld <= '0;
			pending <= '0;
		end else begin
			ent_vld <= nxt_vld;
			pending <= pend_nxt;
		end
	end

	always_ff @(posedge clk) begin
		ent <= nxt;
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

`include "cpu_macros.svh"

module reg_file (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire [`CPU_RIDX-1:0]     i_ra0, i_ra1, i_ra2,
	input  wire [`CPU_RIDX-1:0]     i_ra3, i_ra4, i_ra5,
	input  wire                     i_wb0_vld,
	input  wire [`CPU_RIDX-1:0]     i_wb0_rd,
	input  wire [`CPU_XLEN-1:0]     i_wb0_data,
	input  wire                     i_wb1_vld,
	input  wire [`CPU_RIDX-1:0]     i_wb1_rd,
	input  wire [`CPU_XLEN-1:0]     i_wb1_data,
	output logic [`CPU_XLEN-1:0]    o_rv0, o_rv1, o_rv2,
	output logic [`CPU_XLEN-1:0]    o_rv3, o_rv4, o_rv5
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	// r0 is never written so it keeps its reset zero
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (i_wb0_vld && i_wb0_rd != '0) begin
				regs[i_wb0_rd] <= i_wb0_data;
			end
			if (i_wb1_vld && i_wb1_rd != '0) begin
				regs[i_wb1_rd] <= i_wb1_data;
			end
		end
	end

	assign o_rv0 = regs[i_ra0];
	assign o_rv1 = regs[i_ra1];
	assign o_rv2 = regs[i_ra2];
	assign o_rv3 = regs[i_ra3];
	assign o_rv4 = regs[i_ra4];
	assign o_rv5 = regs[i_ra5];

endmodule

`default_nettype wire

/* hdl/int_alu.sv */
`default_nettype none

`include "cpu_macros.svh"

module int_alu (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire                     i_go,
	input  wire cpu_pkg::opcode_e   i_op,
	input  wire [`CPU_XLEN-1:0]     i_a,
	input  wire [`CPU_XLEN-1:0]     i_b,
	input  wire [15:0]              i_imm,
	input  wire [`CPU_RIDX-1:0]     i_rd,
	output logic                    o_wb_vld,
	output logic [`CPU_RIDX-1:0]    o_wb_rd,
	output logic [`CPU_XLEN-1:0]    o_wb_data
);

	logic [`CPU_XLEN-1:0] result;

	always_comb begin
		case (i_op)
			cpu_pkg::OP_ADD: result = i_a + i_b;
			cpu_pkg::OP_SUB: result = i_a - i_b;
			cpu_pkg::OP_AND: result = i_a & i_b;
			cpu_pkg::OP_OR: result = i_a | i_b;
			cpu_pkg::OP_XOR: result = i_a ^ i_b;
			cpu_pkg::OP_ADDI: result = i_a + {{(`CPU_XLEN-16){i_imm[15]}}, i_imm};
			cpu_pkg::OP_LUI: result = {i_imm, 16'h0000};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_wb_vld <= 1'b0;
		end else begin
			o_wb_vld <= i_go;
		end
	end

	always_ff @(posedge clk) begin
		if (i_go) begin
			o_wb_rd <= i_rd;
			o_wb_data <= result;
		end
	end

endmodule

`default_nettype wire

/* hdl/out_port.sv */
`default_nettype none

`include "cpu_macros.svh"

module out_port (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire                     i_go,
	input  wire [`CPU_XLEN-1:0]     i_data,
	input  wire                     i_out_rdy,
	output logic                    o_out_vld,
	output logic [`CPU_IO_W-1:0]    o_out_data,
	output logic                    o_busy
);

	// the window only strobes while not busy
	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_out_vld <= 1'b0;
		end else if (i_go) begin
			o_out_vld <= 1'b1;
		end else if (o_out_vld && i_out_rdy) begin
			o_out_vld <= 1'b0;
		end
	end

	// byte stays put until accepted
	always_ff @(posedge clk) begin
		if (i_go) begin
			o_out_data <= i_data[`CPU_IO_W-1:0];
		end
	end

	assign o_busy = o_out_vld;

endmodule

`default_nettype wire

/* hdl/cpu_core.sv */
`default_nettype none

`include "cpu_macros.svh"

module cpu_core (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire [`CPU_FETCH_W-1:0]  i_i_rdata,
	input  wire                     i_out_rdy,
	output wire [`CPU_PC_W-2:0]     o_i_addr,
	output wire                     o_out_vld,
	output wire [`CPU_IO_W-1:0]     o_out_data
);

	cpu_pkg::decoded_t slot0, slot1;
	logic slot0_vld, slot1_vld, stall, out_busy;
	logic wb0_vld, wb1_vld, alu0_go, alu1_go, out_go;
	logic [`CPU_RIDX-1:0] wb0_rd, wb1_rd, alu0_rd, alu1_rd;
	logic [`CPU_RIDX-1:0] rs0_idx, rt0_idx, rs1_idx, rt1_idx, rs2_idx, rt2_idx;
	logic [`CPU_XLEN-1:0] rs0_val, rt0_val, rs1_val, rt1_val, rs2_val, rt2_val;
	logic [`CPU_XLEN-1:0] wb0_data, wb1_data, alu0_a, alu0_b, alu1_a, alu1_b, out_data;
	logic [15:0] alu0_imm, alu1_imm;
	cpu_pkg::opcode_e alu0_op, alu1_op;

	fetch_decode u_fetch (
		.clk(clk), .rstn(rstn),
		.i_i_rdata(i_i_rdata), .i_stall(stall), .o_i_addr(o_i_addr),
		.o_slot0(slot0), .o_slot0_vld(slot0_vld),
		.o_slot1(slot1), .o_slot1_vld(slot1_vld)
	);

	issue_window u_window (
		.clk(clk), .rstn(rstn),
		.i_slot0(slot0), .i_slot0_vld(slot0_vld),
		.i_slot1(slot1), .i_slot1_vld(slot1_vld),
		.i_out_busy(out_busy),
		.i_wb0_vld(wb0_vld), .i_wb0_rd(wb0_rd),
		.i_wb1_vld(wb1_vld), .i_wb1_rd(wb1_rd),
		.i_rs0_val(rs0_val), .i_rt0_val(rt0_val), .i_rs1_val(rs1_val),
		.i_rt1_val(rt1_val), .i_rs2_val(rs2_val), .i_rt2_val(rt2_val),
		.o_stall(stall),
		.o_rs0_idx(rs0_idx), .o_rt0_idx(rt0_idx), .o_rs1_idx(rs1_idx),
		.o_rt1_idx(rt1_idx), .o_rs2_idx(rs2_idx), .o_rt2_idx(rt2_idx),
		.o_alu0_go(alu0_go), .o_alu0_op(alu0_op), .o_alu0_a(alu0_a), .o_alu0_b(alu0_b),
		.o_alu0_imm(alu0_imm), .o_alu0_rd(alu0_rd),
		.o_alu1_go(alu1_go), .o_alu1_op(alu1_op), .o_alu1_a(alu1_a), .o_alu1_b(alu1_b),
		.o_alu1_imm(alu1_imm), .o_alu1_rd(alu1_rd),
		.o_out_go(out_go), .o_out_data(out_data)
	);

	reg_file u_rf (
		.clk(clk), .rstn(rstn),
		.i_ra0(rs0_idx), .i_ra1(rt0_idx), .i_ra2(rs1_idx),
		.i_ra3(rt1_idx), .i_ra4(rs2_idx), .i_ra5(rt2_idx),
		.i_wb0_vld(wb0_vld), .i_wb0_rd(wb0_rd), .i_wb0_data(wb0_data),
		.i_wb1_vld(wb1_vld), .i_wb1_rd(wb1_rd), .i_wb1_data(wb1_data),
		.o_rv0(rs0_val), .o_rv1(rt0_val), .o_rv2(rs1_val),
		.o_rv3(rt1_val), .o_rv4(rs2_val), .o_rv5(rt2_val)
	);

	int_alu u_alu0 (
		.clk(clk), .rstn(rstn),
		.i_go(alu0_go), .i_op(alu0_op), .i_a(alu0_a), .i_b(alu0_b),
		.i_imm(alu0_imm), .i_rd(alu0_rd),
		.o_wb_vld(wb0_vld), .o_wb_rd(wb0_rd), .o_wb_data(wb0_data)
	);

	int_alu u_alu1 (
		.clk(clk), .rstn(rstn),
		.i_go(alu1_go), .i_op(alu1_op), .i_a(alu1_a), .i_b(alu1_b),
		.i_imm(alu1_imm), .i_rd(alu1_rd),
		.o_wb_vld(wb1_vld), .o_wb_rd(wb1_rd), .o_wb_data(wb1_data)
	);

	out_port u_out (
		.clk(clk), .rstn(rstn),
		.i_go(out_go), .i_data(out_data), .i_out_rdy(i_out_rdy),
		.o_out_vld(o_out_vld), .o_out_data(o_out_data), .o_busy(out_busy)
	);

endmodule

`default_nettype wire

/* bench/cpu_core_checker.sv */
`default_nettype none

`include "cpu_macros.svh"

module cpu_core_checker (
	input wire                    clk,
	input wire                    rstn,
	input wire                    o_out_vld,
	input wire                    i_out_rdy,
	input wire [`CPU_IO_W-1:0]    o_out_data,
	input wire [`CPU_PC_W-2:0]    o_i_addr
);

	// byte held while the consumer stalls
	hold_data: assert property (@(posedge clk) disable iff (!rstn)
		o_out_vld && !i_out_rdy |=> o_out_vld && $stable(o_out_data))
		else $error("output byte changed before it was accepted");

	reset_quiet: assert property (@(posedge clk) !rstn |=> !o_out_vld)
		else $error("output valid high during reset");

	// first pair after reset is pair 0
	first_fetch: assert property (@(posedge clk) $rose(rstn) |-> o_i_addr == '0)
		else $error("first fetch address after reset is not zero");

endmodule

bind cpu_core cpu_core_checker chk_i (
	.clk(clk), .rstn(rstn),
	.o_out_vld(o_out_vld), .i_out_rdy(i_out_rdy), .o_out_data(o_out_data),
	.o_i_addr(o_i_addr)
);

`default_nettype wire

/* bench/cpu_core_tb.sv */
`default_nettype none

`include "cpu_macros.svh"

module cpu_core_tb;

	localparam int NTESTS = 5;
	localparam int RESET_CYC = 10;
	localparam int DRAIN_CYC = 40;
	// cycle bound per output byte
	localparam int BYTE_BOUND = 50;

	logic clk;
	logic rstn = 1'b0;
	logic [`CPU_FETCH_W-1:0] i_i_rdata = '0;
	logic i_out_rdy = 1'b0;
	wire [`CPU_PC_W-2:0] o_i_addr;
	wire o_out_vld;
	wire [`CPU_IO_W-1:0] o_out_data;

	logic [31:0] prog [0:255];
	logic [7:0] exp_mem [0:255];
	logic [7:0] exp_head;
	logic [7:0] pair_lo;
	logic rdy_random = 1'b0;
	logic [31:0] rnd;
	int exp_cnt = 0;
	int got_cnt = 0;
	int errors = 0;
	int wp = 0;
	int wd_cycles = 0;
	integer seed = 11878;
	string test_name = "none";

	cpu_core dut_i (
		.clk(clk), .rstn(rstn),
		.i_i_rdata(i_i_rdata), .i_out_rdy(i_out_rdy),
		.o_i_addr(o_i_addr), .o_out_vld(o_out_vld), .o_out_data(o_out_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// instruction memory, one cycle latency, upper half is the older instruction
	assign pair_lo = {o_i_addr[6:0], 1'b0};
	always @(posedge clk) begin
		if (o_i_addr[`CPU_PC_W-2:7] == '0)
			i_i_rdata <= {prog[pair_lo], prog[pair_lo | 8'd1]};
		else
			i_i_rdata <= '0;
	end

	always @(posedge clk) begin
		rnd = $random(seed);
		i_out_rdy <= rdy_random ? rnd[0] : 1'b1;
	end

	always @(posedge clk) begin
		if (!rstn)
			got_cnt <= 0;
		else if (o_out_vld && i_out_rdy)
			got_cnt <= got_cnt + 1;
	end

	assign exp_head = exp_mem[got_cnt[7:0]];

	byte_value: assert property (@(posedge clk) disable iff (!rstn)
		o_out_vld && i_out_rdy && got_cnt < exp_cnt |-> o_out_data == exp_head)
		else begin
			errors++;
			$display("FAILED %s: expected %02h, actual %02h", test_name,
				$sampled(exp_head), $sampled(o_out_data));
		end

	no_extra_byte: assert property (@(posedge clk) disable iff (!rstn)
		o_out_vld && i_out_rdy |-> got_cnt < exp_cnt)
		else begin
			errors++;
			$display("%s: output byte beyond the expected sequence", test_name);
		end

	byte_held: assert property (@(posedge clk) disable iff (!rstn)
		o_out_vld && !i_out_rdy |=> o_out_vld && $stable(o_out_data))
		else begin
			errors++;
			$display("%s: output byte changed while ready was low", test_name);
		end

	reset_vld_low: assert property (@(posedge clk) !rstn |=> !o_out_vld)
		else begin
			errors++;
			$display("%s: output valid high during reset", test_name);
		end

	reset_addr_zero: assert property (@(posedge clk) $rose(rstn) |-> o_i_addr == '0)
		else begin
			errors++;
			$display("%s: first fetch address after reset is not zero", test_name);
		end

	function automatic logic [31:0] r_type(cpu_pkg::opcode_e op, int rd, int rs, int rt);
		return {op, rd[4:0], rs[4:0], rt[4:0], 11'd0};
	endfunction

	function automatic logic [31:0] i_type(cpu_pkg::opcode_e op, int rd, int rs, int imm);
		return {op, rd[4:0], rs[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] out_ins(int rs);
		return {cpu_pkg::OP_OUT, 5'd0, rs[4:0], 16'd0};
	endfunction

	function automatic logic [31:0] jump_ins(int target);
		return {cpu_pkg::OP_J, 10'd0, target[15:0]};
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[wp[7:0]] = w;
		wp++;
	endtask

	task automatic load_program(input int n);
		for (int i = 0; i < 256; i++)
			prog[i] = '0;
		wp = 0;
		case (n)
			1: begin
				emit(i_type(cpu_pkg::OP_ADDI, 1, 0, 5));
				emit(i_type(cpu_pkg::OP_ADDI, 2, 1, 7));
				emit(r_type(cpu_pkg::OP_ADD, 3, 1, 2));
				emit(r_type(cpu_pkg::OP_SUB, 4, 3, 1));
				emit(i_type(cpu_pkg::OP_LUI, 5, 0, 'h1234));
				emit(r_type(cpu_pkg::OP_ADD, 6, 5, 4));
				emit(out_ins(3));
				emit(out_ins(4));
				emit(out_ins(6));
				emit(i_type(cpu_pkg::OP_ADDI, 7, 6, -3));
				emit(out_ins(7));
				emit(r_type(cpu_pkg::OP_SUB, 8, 0, 7));
				emit(out_ins(8));
			end
			2: begin
				emit(i_type(cpu_pkg::OP_ADDI, 1, 0, 'h5a));
				emit(i_type(cpu_pkg::OP_ADDI, 2, 0, 'h3c));
				emit(r_type(cpu_pkg::OP_AND, 3, 1, 2));
				emit(r_type(cpu_pkg::OP_OR, 4, 1, 2));
				emit(r_type(cpu_pkg::OP_XOR, 1, 3, 4));
				emit(r_type(cpu_pkg::OP_XOR, 2, 2, 1));
				emit(out_ins(1));
				emit(out_ins(2));
				emit(i_type(cpu_pkg::OP_ADDI, 3, 0, 'h11));
				emit(r_type(cpu_pkg::OP_OR, 3, 3, 1));
				// writes to r0 must vanish
				emit(i_type(cpu_pkg::OP_ADDI, 0, 1, 'h77));
				emit(r_type(cpu_pkg::OP_AND, 0, 1, 2));
				emit(out_ins(0));
				emit(out_ins(3));
				emit(r_type(cpu_pkg::OP_XOR, 4, 0, 3));
				emit(out_ins(4));
			end
			3: begin
				emit(i_type(cpu_pkg::OP_ADDI, 1, 0, 'h21));
				emit(out_ins(1));
				emit(jump_ins(8));
				emit(out_ins(1));
				emit(i_type(cpu_pkg::OP_ADDI, 1, 0, 'h99));
				emit(out_ins(1));
				emit(out_ins(1));
				emit(out_ins(1));
				emit(i_type(cpu_pkg::OP_ADDI, 2, 0, 'h42));
				// jump from the second slot to an odd target
				emit(jump_ins(13));
				emit(out_ins(2));
				emit(out_ins(2));
				emit(out_ins(1));
				emit(out_ins(2));
				emit(i_type(cpu_pkg::OP_ADDI, 1, 1, 1));
				emit(out_ins(1));
			end
			4: begin
				for (int k = 0; k < 16; k++) begin
					emit(i_type(cpu_pkg::OP_ADDI, k % 4 + 1, (k + 3) % 4 + 1, k * 37 + 5));
					emit(out_ins(k % 4 + 1));
				end
			end
			default: begin
			end
		endcase
		// self loop ends the program
		emit(jump_ins(wp));
	endtask

	// sequential model of the program
	task automatic interpret();
		logic [31:0] regs [32];
		logic [31:0] ins, a, b, res;
		logic [4:0] rd, rs, rt;
		logic wr;
		int pc, npc, steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		exp_cnt = 0;
		pc = 0;
		steps = 0;
		while (steps < 2000) begin
			ins = prog[pc[7:0]];
			steps++;
			rd = ins[25:21];
			rs = ins[20:16];
			rt = ins[15:11];
			a = regs[rs];
			b = regs[rt];
			res = '0;
			wr = 1'b1;
			npc = pc + 1;
			case (ins[31:26])
				cpu_pkg::OP_ADD: res = a + b;
				cpu_pkg::OP_SUB: res = a - b;
				cpu_pkg::OP_AND: res = a & b;
				cpu_pkg::OP_OR: res = a | b;
				cpu_pkg::OP_XOR: res = a ^ b;
				cpu_pkg::OP_ADDI: res = a + {{16{ins[15]}}, ins[15:0]};
				cpu_pkg::OP_LUI: res = {ins[15:0], 16'h0000};
				cpu_pkg::OP_OUT: begin
					wr = 1'b0;
					exp_mem[exp_cnt[7:0]] = a[7:0];
					exp_cnt++;
				end
				cpu_pkg::OP_J: begin
					wr = 1'b0;
					npc = int'(ins[13:0]);
				end
				default: wr = 1'b0;
			endcase
			if (wr && rd != 5'd0)
				regs[rd] = res;
			if (ins[31:26] == cpu_pkg::OP_J && npc == pc)
				break;
			pc = npc;
		end
	endtask

	task automatic run_test(input int n, input string name);
		int cyc;
		int err_before;
		err_before = errors;
		@(posedge clk);
		rstn <= 1'b0;
		rdy_random <= (n == 4);
		test_name = name;
		load_program(n);
		interpret();
		repeat (RESET_CYC) @(posedge clk);
		rstn <= 1'b1;
		cyc = 0;
		while (got_cnt < exp_cnt && cyc < (exp_cnt + 1) * BYTE_BOUND) begin
			@(posedge clk);
			cyc++;
		end
		if (got_cnt < exp_cnt) begin
			errors++;
			$display("%s: timed out waiting for output bytes", test_name);
		end
		// look for stray bytes after the last one
		repeat (DRAIN_CYC) @(posedge clk);
		assert (got_cnt == exp_cnt)
		else begin
			errors++;
			$display("FAILED %s: expected %0d bytes, actual %0d", test_name, exp_cnt, got_cnt);
		end
		$display("test %s: %0d of %0d bytes, %0d errors", name, got_cnt, exp_cnt,
			errors - err_before);
	endtask

	initial begin
		int total;
		total = 0;
		for (int n = 0; n < NTESTS; n++) begin
			load_program(n);
			interpret();
			total += exp_cnt;
		end
		exp_cnt = 0;
		wd_cycles = (total + 2 * NTESTS) * BYTE_BOUND + NTESTS * (RESET_CYC + DRAIN_CYC + 4);
		run_test(0, "reset");
		run_test(1, "dep_chain");
		run_test(2, "war_waw");
		run_test(3, "jump");
		run_test(4, "backpressure");
		$display("%0d tests run, %0d errors", NTESTS, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired in test %s", test_name);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_core.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_decode.sv
hdl/issue_window.sv
hdl/reg_file.sv
hdl/int_alu.sv
hdl/out_port.sv
hdl/cpu_core.sv
bench/cpu_core_checker.sv
bench/cpu_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpu_core_tb
FLIST = cpu_core.f
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_MSG = Checks failed
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
